// ==== lpif_pkg.sv ====
/* Sizes and flit layout shared by the four-lane link-layer slave.
   Each lane word is {strobe, marker, 38 payload bits}. The field struct and
   the lane array must both stay exactly FLIT_W bits wide, or the two union
   views no longer overlay the same word. */
package lpif_pkg;

  // PHY lane geometry
  localparam int LANES          = 4;
  localparam int LANE_W         = 40;
  localparam int LANE_PAYLOAD_W = 38;
  localparam int FLIT_W         = LANES * LANE_PAYLOAD_W;

  // Flit fields
  localparam int DATA_W   = 128;
  localparam int CRC_W    = 16;
  localparam int STATE_W  = 4;
  localparam int PROTID_W = 2;

  // Sync block
  localparam int MRK_INTERVAL = 8;
  localparam int MRK_CNT_W    = $clog2(MRK_INTERVAL);
  localparam int DELAY_W      = 16;

  // Top of the flit down to the valid bit in bit 0
  typedef struct packed {
    logic [STATE_W-1:0]  state;
    logic [PROTID_W-1:0] protid;
    logic [DATA_W-1:0]   data;
    logic [CRC_W-1:0]    crc;
    logic                dvalid;
    logic                valid;
  } lpif_fields_t;

  typedef logic [LANE_PAYLOAD_W-1:0] lpif_slice_t;

  // Same flit seen as fields or as lane slices, lane 0 lowest
  typedef union packed {
    lpif_fields_t              fields;
    lpif_slice_t [LANES-1:0]   lanes;
  } lpif_payload_u;

endpackage

// ==== lpif_sync_if.sv ====
/* Side-band from the auto-sync block to the lane striper.
   rx_online_dly is carried here but the receive field map takes it from
   the top level as a plain wire, so the stripe modport leaves it out. */
interface lpif_sync_if;

  logic tx_online_dly;
  logic tx_stb;
  logic tx_mrk;
  logic rx_online_dly;

  // Producer side
  modport sync (
    output tx_online_dly,
    output tx_stb,
    output tx_mrk,
    output rx_online_dly
  );

  // Transmit striper only needs the tx side
  modport stripe (
    input tx_online_dly,
    input tx_stb,
    input tx_mrk
  );

endinterface

// ==== ll_auto_sync.sv ====
/* Online delay and user-bit generation for both link directions.
   A delay of 0 raises the online output on the first edge that samples the
   online input high. The delay counters saturate at all ones, so the delay
   value may change while online without wrapping back to zero. */
module ll_auto_sync (
  input  logic                         clk_wr,
  input  logic                         rst,
  input  logic                         tx_online,
  input  logic                         rx_online,
  input  logic [lpif_pkg::DELAY_W-1:0] delay_x_value,
  input  logic [lpif_pkg::DELAY_W-1:0] delay_y_value,
  lpif_sync_if.sync                    sync
);
  import lpif_pkg::*;

  // Index 0 is transmit, index 1 is receive
  logic [1:0]           online_in;
  logic [DELAY_W-1:0]   delay_val [2];
  logic [DELAY_W-1:0]   dly_cnt   [2];
  logic [1:0]           online_q;
  logic [MRK_CNT_W-1:0] word_cnt;

  assign online_in    = {rx_online, tx_online};
  assign delay_val[0] = delay_y_value;
  assign delay_val[1] = delay_x_value;

  ////////////////////////////////////////////////////////////////////////////
  // Online delay counters

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      for (int i = 0; i < 2; i++) begin
        dly_cnt[i] <= '0;
      end
      online_q <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!online_in[i]) begin
          // Any low sample restarts the wait
          dly_cnt[i]  <= '0;
          online_q[i] <= 1'b0;
        end else begin
          if (dly_cnt[i] != '1) begin
            dly_cnt[i] <= dly_cnt[i] + 1'b1;
          end
          if (dly_cnt[i] >= delay_val[i]) begin
            online_q[i] <= 1'b1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Marker word counter

  // Word 0 is the first word after tx goes online
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      word_cnt <= '0;
    end else if (!online_q[0]) begin
      word_cnt <= '0;
    end else if (word_cnt == MRK_CNT_W'(MRK_INTERVAL - 1)) begin
      word_cnt <= '0;
    end else begin
      word_cnt <= word_cnt + 1'b1;
    end
  end

  assign sync.tx_online_dly = online_q[0];
  assign sync.rx_online_dly = online_q[1];
  // Strobe is persistent while online
  assign sync.tx_stb        = online_q[0];
  assign sync.tx_mrk        = online_q[0] && (word_cnt == '0);

endmodule

// ==== lpif_field_map.sv ====
/* Packs upstream fields into the flit and unpacks received flits.
   Transmit packing is combinational, the lane striper adds the register.
   Downstream outputs are registered and held at zero while the receive
   direction is offline, including the dvalid and valid flags. */
module lpif_field_map (
  input  logic                          clk_wr,
  input  logic                          rst,
  input  logic                          rx_online_dly,

  // Upstream channel
  input  logic [lpif_pkg::STATE_W-1:0]  ustrm_state,
  input  logic [lpif_pkg::PROTID_W-1:0] ustrm_protid,
  input  logic [lpif_pkg::DATA_W-1:0]   ustrm_data,
  input  logic [lpif_pkg::CRC_W-1:0]    ustrm_crc,
  input  logic                          ustrm_dvalid,
  input  logic                          ustrm_valid,

  // Flit payloads to and from the lane striper
  input  lpif_pkg::lpif_payload_u       rx_payload,
  output lpif_pkg::lpif_payload_u       tx_payload,

  // Downstream channel
  output logic [lpif_pkg::STATE_W-1:0]  dstrm_state,
  output logic [lpif_pkg::PROTID_W-1:0] dstrm_protid,
  output logic [lpif_pkg::DATA_W-1:0]   dstrm_data,
  output logic [lpif_pkg::CRC_W-1:0]    dstrm_crc,
  output logic                          dstrm_dvalid,
  output logic                          dstrm_valid
);
  import lpif_pkg::*;

  lpif_fields_t rx_fields;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit packing

  always_comb begin
    tx_payload.fields.state  = ustrm_state;
    tx_payload.fields.protid = ustrm_protid;
    tx_payload.fields.data   = ustrm_data;
    tx_payload.fields.crc    = ustrm_crc;
    tx_payload.fields.dvalid = ustrm_dvalid;
    tx_payload.fields.valid  = ustrm_valid;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receive unpacking

  assign rx_fields = rx_payload.fields;

  always_ff @(posedge clk_wr) begin
    if (rst || !rx_online_dly) begin
      dstrm_state  <= '0;
      dstrm_protid <= '0;
      dstrm_data   <= '0;
      dstrm_crc    <= '0;
      dstrm_dvalid <= 1'b0;
      dstrm_valid  <= 1'b0;
    end else begin
      dstrm_state  <= rx_fields.state;
      dstrm_protid <= rx_fields.protid;
      dstrm_data   <= rx_fields.data;
      dstrm_crc    <= rx_fields.crc;
      dstrm_dvalid <= rx_fields.dvalid;
      dstrm_valid  <= rx_fields.valid;
    end
  end

endmodule

// ==== lpif_lane_stripe.sv ====
/* Splits the flit across the PHY lanes and rebuilds it on receive.
   Transmit lanes are registered, giving one clock from ustrm to tx_phy.
   Received strobe and marker bits are dropped without any alignment
   check, so the far end must already be word aligned. */
module lpif_lane_stripe (
  input  logic                         clk_wr,
  input  logic                         rst,
  input  lpif_pkg::lpif_payload_u      tx_payload,

  input  logic [lpif_pkg::LANE_W-1:0]  rx_phy0,
  input  logic [lpif_pkg::LANE_W-1:0]  rx_phy1,
  input  logic [lpif_pkg::LANE_W-1:0]  rx_phy2,
  input  logic [lpif_pkg::LANE_W-1:0]  rx_phy3,

  lpif_sync_if.stripe                  sync,

  output logic [lpif_pkg::LANE_W-1:0]  tx_phy0,
  output logic [lpif_pkg::LANE_W-1:0]  tx_phy1,
  output logic [lpif_pkg::LANE_W-1:0]  tx_phy2,
  output logic [lpif_pkg::LANE_W-1:0]  tx_phy3,
  output lpif_pkg::lpif_payload_u      rx_payload
);
  import lpif_pkg::*;

  logic [LANE_W-1:0] tx_lane_q [LANES];
  logic [LANE_W-1:0] rx_lane   [LANES];

  ////////////////////////////////////////////////////////////////////////////
  // Transmit lanes

  // Lane word is {strobe, marker, slice}
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      for (int i = 0; i < LANES; i++) begin
        tx_lane_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < LANES; i++) begin
        if (sync.tx_online_dly) begin
          tx_lane_q[i] <= {sync.tx_stb, sync.tx_mrk, tx_payload.lanes[i]};
        end else begin
          tx_lane_q[i] <= '0;
        end
      end
    end
  end

  assign tx_phy0 = tx_lane_q[0];
  assign tx_phy1 = tx_lane_q[1];
  assign tx_phy2 = tx_lane_q[2];
  assign tx_phy3 = tx_lane_q[3];

  ////////////////////////////////////////////////////////////////////////////
  // Receive lanes

  assign rx_lane[0] = rx_phy0;
  assign rx_lane[1] = rx_phy1;
  assign rx_lane[2] = rx_phy2;
  assign rx_lane[3] = rx_phy3;

  // Strip user bits 39 and 38
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      rx_payload.lanes[i] = rx_lane[i][LANE_PAYLOAD_W-1:0];
    end
  end

endmodule

// ==== lpif_slave_top.sv ====
/* Four-lane link-layer slave, single clock domain on clk_wr.
   No FIFO or credit logic; one flit moves each way every cycle and the
   valid bit inside the flit marks meaningful words. Latency is one clock
   in each direction once the programmed online delays have expired. */
module lpif_slave_top (
  input  logic                          clk_wr,
  input  logic                          rst,

  // Control
  input  logic                          tx_online,
  input  logic                          rx_online,
  input  logic [lpif_pkg::DELAY_W-1:0]  delay_x_value,
  input  logic [lpif_pkg::DELAY_W-1:0]  delay_y_value,

  // PHY lanes
  output logic [lpif_pkg::LANE_W-1:0]   tx_phy0,
  input  logic [lpif_pkg::LANE_W-1:0]   rx_phy0,
  output logic [lpif_pkg::LANE_W-1:0]   tx_phy1,
  input  logic [lpif_pkg::LANE_W-1:0]   rx_phy1,
  output logic [lpif_pkg::LANE_W-1:0]   tx_phy2,
  input  logic [lpif_pkg::LANE_W-1:0]   rx_phy2,
  output logic [lpif_pkg::LANE_W-1:0]   tx_phy3,
  input  logic [lpif_pkg::LANE_W-1:0]   rx_phy3,

  // Downstream channel
  output logic [lpif_pkg::STATE_W-1:0]  dstrm_state,
  output logic [lpif_pkg::PROTID_W-1:0] dstrm_protid,
  output logic [lpif_pkg::DATA_W-1:0]   dstrm_data,
  output logic [lpif_pkg::CRC_W-1:0]    dstrm_crc,
  output logic                          dstrm_dvalid,
  output logic                          dstrm_valid,

  // Upstream channel
  input  logic [lpif_pkg::STATE_W-1:0]  ustrm_state,
  input  logic [lpif_pkg::PROTID_W-1:0] ustrm_protid,
  input  logic [lpif_pkg::DATA_W-1:0]   ustrm_data,
  input  logic [lpif_pkg::CRC_W-1:0]    ustrm_crc,
  input  logic                          ustrm_dvalid,
  input  logic                          ustrm_valid
);
  import lpif_pkg::*;

  lpif_payload_u tx_payload;
  lpif_payload_u rx_payload;

  lpif_sync_if sync_if_i ();

  ////////////////////////////////////////////////////////////////////////////
  // Sync

  ll_auto_sync ll_auto_sync_i (
    .clk_wr        (clk_wr),
    .rst           (rst),
    .tx_online     (tx_online),
    .rx_online     (rx_online),
    .delay_x_value (delay_x_value),
    .delay_y_value (delay_y_value),
    .sync          (sync_if_i.sync)
  );

  ////////////////////////////////////////////////////////////////////////////
  // User interface

  lpif_field_map lpif_field_map_i (
    .clk_wr        (clk_wr),
    .rst           (rst),
    .rx_online_dly (sync_if_i.rx_online_dly),
    .ustrm_state   (ustrm_state),
    .ustrm_protid  (ustrm_protid),
    .ustrm_data    (ustrm_data),
    .ustrm_crc     (ustrm_crc),
    .ustrm_dvalid  (ustrm_dvalid),
    .ustrm_valid   (ustrm_valid),
    .rx_payload    (rx_payload),
    .tx_payload    (tx_payload),
    .dstrm_state   (dstrm_state),
    .dstrm_protid  (dstrm_protid),
    .dstrm_data    (dstrm_data),
    .dstrm_crc     (dstrm_crc),
    .dstrm_dvalid  (dstrm_dvalid),
    .dstrm_valid   (dstrm_valid)
  );

  ////////////////////////////////////////////////////////////////////////////
  // PHY interface

  lpif_lane_stripe lpif_lane_stripe_i (
    .clk_wr     (clk_wr),
    .rst        (rst),
    .tx_payload (tx_payload),
    .rx_phy0    (rx_phy0),
    .rx_phy1    (rx_phy1),
    .rx_phy2    (rx_phy2),
    .rx_phy3    (rx_phy3),
    .sync       (sync_if_i.stripe),
    .tx_phy0    (tx_phy0),
    .tx_phy1    (tx_phy1),
    .tx_phy2    (tx_phy2),
    .tx_phy3    (tx_phy3),
    .rx_payload (rx_payload)
  );

endmodule

// ==== tb_lpif_slave.sv ====
/* Random-stimulus testbench for the four-lane link-layer slave.
   A cycle model predicts every tx_phy lane and the downstream flit from the
   online delay, marker and slicing rules. Inputs change 1 unit after each
   rising edge. Wrap-back feeds tx_phy into rx_phy in the last test. */
module tb_lpif_slave;
  import lpif_pkg::*;

  localparam int RST_CYC = 5;
  localparam int T1_CYC  = 20;
  localparam int T2_CYC  = 100;
  localparam int T3_CYC  = 200;
  localparam int T4_CYC  = 45;
  localparam int T5_CYC  = 60;
  localparam int TOTAL_CYC = RST_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC;

  logic clk_wr, rst, tx_online, rx_online, wrap;
  logic [DELAY_W-1:0] delay_x_value, delay_y_value;
  logic [LANE_W-1:0] tx_phy [LANES];
  logic [LANE_W-1:0] rx_phy [LANES];
  logic [LANE_W-1:0] rx_rand [LANES];
  logic [STATE_W-1:0] ustrm_state, dstrm_state;
  logic [PROTID_W-1:0] ustrm_protid, dstrm_protid;
  logic [DATA_W-1:0] ustrm_data, dstrm_data;
  logic [CRC_W-1:0] ustrm_crc, dstrm_crc;
  logic ustrm_dvalid, dstrm_dvalid, ustrm_valid, dstrm_valid;

  // Model state
  logic [LANE_W-1:0] m_phy [LANES];
  logic [FLIT_W-1:0] m_dstrm;
  int m_tx_run, m_rx_run, m_words, n, errors;
  logic m_tx_on, m_rx_on;
  logic [31:0] rng_state;
  string test_name;

  lpif_slave_top lpif_slave_top_i (
    .clk_wr(clk_wr), .rst(rst), .tx_online(tx_online), .rx_online(rx_online),
    .delay_x_value(delay_x_value), .delay_y_value(delay_y_value),
    .tx_phy0(tx_phy[0]), .rx_phy0(rx_phy[0]), .tx_phy1(tx_phy[1]), .rx_phy1(rx_phy[1]),
    .tx_phy2(tx_phy[2]), .rx_phy2(rx_phy[2]), .tx_phy3(tx_phy[3]), .rx_phy3(rx_phy[3]),
    .dstrm_state(dstrm_state), .dstrm_protid(dstrm_protid), .dstrm_data(dstrm_data),
    .dstrm_crc(dstrm_crc), .dstrm_dvalid(dstrm_dvalid), .dstrm_valid(dstrm_valid),
    .ustrm_state(ustrm_state), .ustrm_protid(ustrm_protid), .ustrm_data(ustrm_data),
    .ustrm_crc(ustrm_crc), .ustrm_dvalid(ustrm_dvalid), .ustrm_valid(ustrm_valid)
  );

  // Wrap-back path from the transmit lanes
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      rx_phy[i] = wrap ? tx_phy[i] : rx_rand[i];
    end
  end

  initial begin
    clk_wr = 1'b0;
    forever #4 clk_wr = ~clk_wr;
  end

  function automatic logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic compare_value(input string name, input logic [159:0] exp,
                               input logic [159:0] act);
    if (exp !== act) begin
      errors++;
      $display("** Error [%s] expected %h, actual %h", name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One clock: advance the model, check outputs, drive new inputs

  task automatic run_cycle();
    logic [FLIT_W-1:0] flit;
    logic [FLIT_W-1:0] rx_flit;
    logic [LANE_W-1:0] rx_word;
    @(posedge clk_wr);
    flit = {ustrm_state, ustrm_protid, ustrm_data, ustrm_crc, ustrm_dvalid, ustrm_valid};
    for (int i = 0; i < LANES; i++) begin
      rx_word = wrap ? m_phy[i] : rx_rand[i];
      rx_flit[i*LANE_PAYLOAD_W +: LANE_PAYLOAD_W] = rx_word[LANE_PAYLOAD_W-1:0];
    end
    m_dstrm = (m_rx_on && !rst) ? rx_flit : '0;
    for (int i = 0; i < LANES; i++) begin
      m_phy[i] = (m_tx_on && !rst) ?
                 {1'b1, m_words % MRK_INTERVAL == 0, flit[i*LANE_PAYLOAD_W +: LANE_PAYLOAD_W]}
                 : '0;
    end
    m_words = m_tx_on ? m_words + 1 : 0;
    // Online after delay+1 consecutive high samples
    m_tx_run = (tx_online && !rst) ? m_tx_run + 1 : 0;
    m_rx_run = (rx_online && !rst) ? m_rx_run + 1 : 0;
    m_tx_on = m_tx_run >= int'(delay_y_value) + 1;
    m_rx_on = m_rx_run >= int'(delay_x_value) + 1;
    #1;
    for (int i = 0; i < LANES; i++) begin
      compare_value($sformatf("%s tx_phy%0d", test_name, i), m_phy[i], tx_phy[i]);
    end
    compare_value({test_name, " dstrm"}, m_dstrm, {dstrm_state, dstrm_protid, dstrm_data,
                  dstrm_crc, dstrm_dvalid, dstrm_valid});
    ustrm_state = STATE_W'(rand32());
    ustrm_protid = PROTID_W'(rand32());
    ustrm_data = {rand32(), rand32(), rand32(), rand32()};
    ustrm_crc = CRC_W'(rand32());
    ustrm_dvalid = 1'(rand32());
    ustrm_valid = 1'(rand32());
    for (int i = 0; i < LANES; i++) begin
      rx_rand[i] = LANE_W'({rand32(), rand32()});
    end
  endtask

  // Raise tx_online and count clocks up to the first nonzero lane word
  task automatic measure_tx_delay(input int delay);
    delay_y_value = DELAY_W'(delay);
    tx_online = 1'b1;
    n = 0;
    do begin
      run_cycle();
      n++;
    end while (tx_phy[0] == '0 && n < 40);
    compare_value({test_name, " latency"}, delay + 2, n);
    tx_online = 1'b0;
    repeat (3) run_cycle();
  endtask

  initial begin
    #(TOTAL_CYC * 8 + 400);
    $display("Timeout: run did not finish within %0d clock cycles", TOTAL_CYC + 50);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    rng_state = 32'd55;
    errors = 0;
    {rst, tx_online, rx_online, wrap} = 4'b1000;
    {delay_x_value, delay_y_value} = '0;
    {ustrm_state, ustrm_protid, ustrm_data, ustrm_crc, ustrm_dvalid, ustrm_valid} = '0;
    for (int i = 0; i < LANES; i++) begin
      rx_rand[i] = '0;
      m_phy[i] = '0;
    end
    {m_tx_run, m_rx_run, m_words, m_tx_on, m_rx_on} = '0;
    test_name = "reset";
    repeat (RST_CYC) run_cycle();
    rst = 1'b0;
    repeat (T1_CYC) run_cycle();

    test_name = "tx_delay";
    measure_tx_delay(5);
    measure_tx_delay(int'(rand32() % 8));

    test_name = "striping";
    delay_y_value = '0;
    tx_online = 1'b1;
    repeat (T3_CYC) run_cycle();

    // Toggle mid-group so the marker count has to restart
    test_name = "marker";
    repeat (3) run_cycle();
    tx_online = 1'b0;
    run_cycle();
    tx_online = 1'b1;
    delay_y_value = 2;
    repeat (T4_CYC - 4) run_cycle();

    test_name = "wrap_back";
    wrap = 1'b1;
    delay_x_value = DELAY_W'(rand32() % 10 + 2);
    rx_online = 1'b1;
    repeat (T5_CYC) run_cycle();

    $display("Checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
lpif_pkg.sv
lpif_sync_if.sv
ll_auto_sync.sv
lpif_field_map.sv
lpif_lane_stripe.sv
lpif_slave_top.sv
tb_lpif_slave.sv
